// ==== source/video_pkg.sv ====
// Shrunk test geometry, one pixel per clk; widths below are fixed and shared by every block
`default_nettype none

package video_pkg;

    // Horizontal geometry in clocks, visible pixels at hdump 0 to 63
    localparam int H_TOTAL  = 80;
    localparam int H_ACTIVE = 64;
    localparam int HS_START = 68;
    localparam int HS_END   = 72;

    // Vertical geometry in lines
    localparam int V_TOTAL   = 40;
    localparam int V_ACTIVE  = 32;
    localparam int VS_START  = 34;
    localparam int VS_END    = 36;
    localparam int VINT_LINE = 32;

    // Timer position to rgb latency
    localparam int PIPE_DLY = 3;

    typedef enum logic [2:0] {
        REG_SCR1_HPOS = 3'd0,
        REG_SCR1_VPOS = 3'd1,
        REG_SCR2_HPOS = 3'd2,
        REG_SCR2_VPOS = 3'd3,
        REG_PAGES     = 3'd4
    } mmr_reg_e;

    // CPU write strobe bus, dsn active low per byte lane
    typedef struct packed {
        logic [2:0]  addr;
        logic [15:0] data;
        logic [1:0]  dsn;
    } cpu_bus_t;

    typedef struct packed {
        logic [8:0] hpos;
        logic [8:0] vpos;
        logic [1:0] page;
    } scroll_regs_t;

    typedef struct packed {
        logic [8:0] hdump;
        logic [8:0] vdump;
        logic       hb;
        logic       vb;
        logic       hs;
        logic       vs;
        logic       hstart;
    } video_timing_t;

    // Colour 0 is transparent on the front layer
    typedef struct packed {
        logic [3:0] color;
    } layer_pxl_t;

    typedef struct packed {
        logic [4:0] red;
        logic [4:0] green;
        logic [4:0] blue;
    } rgb_t;

endpackage

`default_nettype wire

// ==== source/video_timer.sv ====
// Free-running timer with no pixel enable; all outputs are registered and valid from reset
`default_nettype none
`timescale 1ns/1ps

module video_timer
    import video_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    output video_timing_t timing,
    output logic          vint
);

    logic [8:0] h_nxt;
    logic [8:0] v_nxt;

    // Next position, the line counter steps on the last clock of a line
    always_comb begin
        h_nxt = timing.hdump + 9'd1;
        v_nxt = timing.vdump;
        if (timing.hdump == 9'(H_TOTAL - 1)) begin
            h_nxt = '0;
            if (timing.vdump == 9'(V_TOTAL - 1)) begin
                v_nxt = '0;
            end else begin
                v_nxt = timing.vdump + 9'd1;
            end
        end
    end

    // Decode from the next position so flags line up with the counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            timing        <= '0;
            timing.hstart <= 1'b1;
            vint          <= 1'b0;
        end else begin
            timing.hdump  <= h_nxt;
            timing.vdump  <= v_nxt;
            timing.hb     <= h_nxt >= 9'(H_ACTIVE);
            timing.vb     <= v_nxt >= 9'(V_ACTIVE);
            timing.hs     <= (h_nxt >= 9'(HS_START)) && (h_nxt < 9'(HS_END));
            timing.vs     <= (v_nxt >= 9'(VS_START)) && (v_nxt < 9'(VS_END));
            timing.hstart <= h_nxt == '0;
            // One clock at the start of the interrupt line
            vint          <= (h_nxt == '0) && (v_nxt == 9'(VINT_LINE));
        end
    end

    a_hdump_range: assert property (@(posedge clk) disable iff (!rst_n)
        timing.hdump < 9'(H_TOTAL))
        else $error("hdump out of range");

    a_vint_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        vint |=> !vint)
        else $error("vint longer than one clock");

endmodule

`default_nettype wire

// ==== source/video_mmr.sv ====
// Write-only strobe port with byte lanes; st_dout shows only the low byte, unused indices read 0
`default_nettype none
`timescale 1ns/1ps

module video_mmr
    import video_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         mmr_cs,
    input  cpu_bus_t     cpu_bus,
    output scroll_regs_t scr1,
    output scroll_regs_t scr2,
    input  logic [2:0]   st_addr,
    output logic [7:0]   st_dout
);

    logic [15:0] mmr [0:int'(REG_PAGES)];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i <= int'(REG_PAGES); i++) begin
                mmr[i] <= '0;
            end
        end else if (mmr_cs && (cpu_bus.addr <= REG_PAGES)) begin
            if (!cpu_bus.dsn[0]) begin
                mmr[cpu_bus.addr][7:0] <= cpu_bus.data[7:0];
            end
            if (!cpu_bus.dsn[1]) begin
                mmr[cpu_bus.addr][15:8] <= cpu_bus.data[15:8];
            end
        end
    end

    // Layer 1 takes page bits 1:0, layer 2 bits 3:2
    always_comb begin
        scr1.hpos = mmr[REG_SCR1_HPOS][8:0];
        scr1.vpos = mmr[REG_SCR1_VPOS][8:0];
        scr1.page = mmr[REG_PAGES][1:0];
        scr2.hpos = mmr[REG_SCR2_HPOS][8:0];
        scr2.vpos = mmr[REG_SCR2_VPOS][8:0];
        scr2.page = mmr[REG_PAGES][3:2];
    end

    // Status readback
    always_comb begin
        case (mmr_reg_e'(st_addr))
            REG_SCR1_HPOS, REG_SCR1_VPOS, REG_SCR2_HPOS, REG_SCR2_VPOS, REG_PAGES:
                st_dout = mmr[st_addr][7:0];
            default:
                st_dout = '0;
        endcase
    end

    a_unused_write: assert property (@(posedge clk) disable iff (!rst_n)
        mmr_cs |-> (cpu_bus.addr <= REG_PAGES))
        else $error("write to unused register index %0d", cpu_bus.addr);

endmodule

`default_nettype wire

// ==== source/scroll_layer.sv ====
// Bitmap layer without tile map or flip; expects rom_data for rom_addr in the same clock
`default_nettype none
`timescale 1ns/1ps

module scroll_layer
    import video_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  video_timing_t timing,
    input  scroll_regs_t  regs,
    output logic [13:0]   rom_addr,
    input  logic [31:0]   rom_data,
    output layer_pxl_t    pxl
);

    // Scroll values held for the whole line
    scroll_regs_t line_regs;
    scroll_regs_t cur_regs;
    logic [8:0]   scr_x;
    logic [8:0]   scr_y;
    logic [2:0]   nib_sel;

    // On the line start clock the live registers apply at once,
    // so every pixel of a line sees the same scroll
    always_comb begin
        cur_regs = timing.hstart ? regs : line_regs;
        scr_x    = timing.hdump + cur_regs.hpos;
        scr_y    = timing.vdump + cur_regs.vpos;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            line_regs <= '0;
        end else if (timing.hstart) begin
            line_regs <= regs;
        end
    end

    // First stage forms the word address of 8 pixels
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rom_addr <= '0;
            nib_sel  <= '0;
        end else begin
            rom_addr <= {4'd0, cur_regs.page, scr_y[4:0], scr_x[5:3]};
            nib_sel  <= scr_x[2:0];
        end
    end

    // Second stage picks one nibble with the leftmost pixel in bits 3:0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pxl <= '0;
        end else begin
            pxl.color <= rom_data[{nib_sel, 2'b00} +: 4];
        end
    end

endmodule

`default_nettype wire

// ==== source/color_mixer.sv ====
// Two-layer priority only, 32-entry 5-5-5 palette; pal_dout lags cpu_pal_addr by one clock
`default_nettype none
`timescale 1ns/1ps

module color_mixer
    import video_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          pal_cs,
    input  cpu_bus_t      cpu_bus,
    input  logic [4:0]    cpu_pal_addr,
    output logic [15:0]   pal_dout,
    input  video_timing_t timing,
    input  layer_pxl_t    back_pxl,
    input  layer_pxl_t    front_pxl,
    output rgb_t          rgb
);

    // Entries 0 to 15 back layer, 16 to 31 front layer
    logic [14:0] pal_ram [32];

    // Blanking delayed to the pixel stage
    logic [PIPE_DLY-2:0] blank_sr;
    logic [4:0]          pal_idx;

    always_ff @(posedge clk) begin
        if (pal_cs) begin
            if (!cpu_bus.dsn[0]) begin
                pal_ram[cpu_pal_addr][7:0] <= cpu_bus.data[7:0];
            end
            if (!cpu_bus.dsn[1]) begin
                pal_ram[cpu_pal_addr][14:8] <= cpu_bus.data[14:8];
            end
        end
    end

    // CPU readback, bit 15 is not stored
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pal_dout <= '0;
        end else begin
            pal_dout <= {1'b0, pal_ram[cpu_pal_addr]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            blank_sr <= '0;
        end else begin
            blank_sr <= {blank_sr[PIPE_DLY-3:0], timing.hb | timing.vb};
        end
    end

    // Front wins unless transparent
    always_comb begin
        if (front_pxl.color != 4'd0) begin
            pal_idx = {1'b1, front_pxl.color};
        end else begin
            pal_idx = {1'b0, back_pxl.color};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || blank_sr[PIPE_DLY-2]) begin
            rgb <= '0;
        end else begin
            rgb <= rgb_t'(pal_ram[pal_idx]);
        end
    end

    a_blank_black: assert property (@(posedge clk) disable iff (!rst_n)
        (timing.hb || timing.vb) |-> ##PIPE_DLY (rgb == '0))
        else $error("rgb not black in blanking");

endmodule

`default_nettype wire

// ==== source/video_top.sv ====
// Graphics ROMs must answer combinationally; rgb trails hdump/vdump by PIPE_DLY clocks
`default_nettype none
`timescale 1ns/1ps

module video_top
    import video_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    // CPU side
    input  logic        mmr_cs,
    input  logic        pal_cs,
    input  cpu_bus_t    cpu_bus,
    input  logic [4:0]  cpu_pal_addr,
    input  logic [2:0]  st_addr,
    output logic [7:0]  st_dout,
    output logic [15:0] pal_dout,

    // Graphics ROMs, layer 1 is the back layer
    output logic [13:0] rom1_addr,
    input  logic [31:0] rom1_data,
    output logic [13:0] rom2_addr,
    input  logic [31:0] rom2_data,

    // Video out
    output logic [8:0]  hdump,
    output logic [8:0]  vdump,
    output logic        hblank,
    output logic        vblank,
    output logic        hs,
    output logic        vs,
    output logic        vint,
    output rgb_t        rgb
);

    video_timing_t timing;
    scroll_regs_t  scr1;
    scroll_regs_t  scr2;
    layer_pxl_t    back_pxl;
    layer_pxl_t    front_pxl;

    assign hdump  = timing.hdump;
    assign vdump  = timing.vdump;
    assign hblank = timing.hb;
    assign vblank = timing.vb;
    assign hs     = timing.hs;
    assign vs     = timing.vs;

    video_timer u_timer (
        .clk    ( clk    ),
        .rst_n  ( rst_n  ),
        .timing ( timing ),
        .vint   ( vint   )
    );

    video_mmr u_mmr (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .mmr_cs  ( mmr_cs  ),
        .cpu_bus ( cpu_bus ),
        .scr1    ( scr1    ),
        .scr2    ( scr2    ),
        .st_addr ( st_addr ),
        .st_dout ( st_dout )
    );

    scroll_layer u_scr_back (
        .clk      ( clk       ),
        .rst_n    ( rst_n     ),
        .timing   ( timing    ),
        .regs     ( scr1      ),
        .rom_addr ( rom1_addr ),
        .rom_data ( rom1_data ),
        .pxl      ( back_pxl  )
    );

    scroll_layer u_scr_front (
        .clk      ( clk       ),
        .rst_n    ( rst_n     ),
        .timing   ( timing    ),
        .regs     ( scr2      ),
        .rom_addr ( rom2_addr ),
        .rom_data ( rom2_data ),
        .pxl      ( front_pxl )
    );

    color_mixer u_colmix (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .pal_cs       ( pal_cs       ),
        .cpu_bus      ( cpu_bus      ),
        .cpu_pal_addr ( cpu_pal_addr ),
        .pal_dout     ( pal_dout     ),
        .timing       ( timing       ),
        .back_pxl     ( back_pxl     ),
        .front_pxl    ( front_pxl    ),
        .rgb          ( rgb          )
    );

endmodule

`default_nettype wire

// ==== verif/tb_video_model.svh ====
// Included inside tb_video_top only; ROM images and palette must stay fixed while rgb is checked
`ifndef TB_VIDEO_MODEL_SVH
`define TB_VIDEO_MODEL_SVH

logic [31:0]  lcg_state = 32'h8a0d_1dd1;
logic [31:0]  rom1_img [16384];
logic [31:0]  rom2_img [16384];
logic [14:0]  model_pal [32];
logic [15:0]  model_mmr [5];

// Scroll copies taken at each line start
scroll_regs_t line1;
scroll_regs_t line2;

// Predicted rgb of the last three positions with the oldest at index 2
rgb_t         exp_hist [3];
int           hist_cnt;
int           err_cnt;

// ROM word addresses of the previous position
logic [13:0]  exp_addr1;
logic [13:0]  exp_addr2;

// Numerical Recipes constants with the high half folded into the low bits
function automatic logic [31:0] rand_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state ^ {16'd0, lcg_state[31:16]};
endfunction

function automatic logic [15:0] lane_merge(logic [15:0] old, logic [15:0] data, logic [1:0] dsn);
    logic [15:0] res;
    res = old;
    if (!dsn[0])
        res[7:0] = data[7:0];
    if (!dsn[1])
        res[15:8] = data[15:8];
    return res;
endfunction

// Layer 0 uses registers 0 and 1 with page bits 1:0 and layer 1 registers 2 and 3 with bits 3:2
function automatic scroll_regs_t layer_regs(int layer);
    scroll_regs_t r;
    r.hpos = model_mmr[2 * layer][8:0];
    r.vpos = model_mmr[2 * layer + 1][8:0];
    r.page = (layer == 0) ? model_mmr[4][1:0] : model_mmr[4][3:2];
    return r;
endfunction

// Word is page, then y mod 32, then x / 8 mod 8
function automatic logic [13:0] layer_addr(scroll_regs_t r, int h, int v);
    logic [8:0] sx;
    logic [8:0] sy;
    sx = 9'(h) + r.hpos;
    sy = 9'(v) + r.vpos;
    return 14'(int'(r.page) * 256 + int'(sy[4:0]) * 8 + int'(sx[5:3]));
endfunction

// Pixel x mod 8 counts from the low nibble
function automatic logic [3:0] layer_pixel(logic front, scroll_regs_t r, int h, int v);
    logic [8:0]  sx;
    logic [13:0] addr;
    logic [31:0] word;
    sx   = 9'(h) + r.hpos;
    addr = layer_addr(r, h, v);
    word = front ? rom2_img[addr] : rom1_img[addr];
    return 4'(word >> (4 * int'(sx[2:0])));
endfunction

function automatic rgb_t predict_rgb(int h, int v);
    logic [3:0] back;
    logic [3:0] front;
    if (h >= H_ACTIVE || v >= V_ACTIVE)
        return '0;
    back  = layer_pixel(1'b0, line1, h, v);
    front = layer_pixel(1'b1, line2, h, v);
    if (front != 4'd0)
        return rgb_t'(model_pal[16 + int'(front)]);
    return rgb_t'(model_pal[int'(back)]);
endfunction

task automatic check_rgb(string name, rgb_t got, rgb_t exp);
    if (got !== exp) begin
        err_cnt++;
        $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_addr(string name, logic [13:0] got, logic [13:0] exp);
    if (got !== exp) begin
        err_cnt++;
        $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_byte(string name, logic [7:0] got, logic [7:0] exp);
    if (got !== exp) begin
        err_cnt++;
        $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_word(string name, logic [15:0] got, logic [15:0] exp);
    if (got !== exp) begin
        err_cnt++;
        $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
        err_cnt++;
        $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
    end
endtask

`endif

// ==== verif/tb_video_top.sv ====
// Graphics ROMs are combinational arrays here; palette and ROMs must not change while rgb is checked
`default_nettype none
`timescale 1ns/1ps

module tb_video_top
    import video_pkg::*;
();

    localparam int FRAME_CLKS = H_TOTAL * V_TOTAL;

    logic        clk;
    logic        rst_n;
    logic        mmr_cs;
    logic        pal_cs;
    cpu_bus_t    cpu_bus;
    logic [4:0]  cpu_pal_addr;
    logic [2:0]  st_addr;
    logic [7:0]  st_dout;
    logic [15:0] pal_dout;
    logic [13:0] rom1_addr;
    logic [31:0] rom1_data;
    logic [13:0] rom2_addr;
    logic [31:0] rom2_data;
    logic [8:0]  hdump;
    logic [8:0]  vdump;
    logic        hblank;
    logic        vblank;
    logic        hs;
    logic        vs;
    logic        vint;
    rgb_t        rgb;

    // Model position of the current sample
    int          m_h;
    int          m_v;
    logic        pos_sync;
    logic        video_check;
    int          front_wins;
    int          back_shows;
    int          tests_run;
    int          tests_failed;
    int          test_err_base;

    `include "tb_video_model.svh"

    assign rom1_data = rom1_img[rom1_addr];
    assign rom2_data = rom2_img[rom2_addr];

    video_top i_video_top (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // One clock with outputs sampled 1 ns after the edge and inputs driven after return
    task automatic step();
        rgb_t pred;
        @(posedge clk);
        #1;
        if (pos_sync) begin
            m_h = (m_h + 1) % H_TOTAL;
            if (m_h == 0)
                m_v = (m_v + 1) % V_TOTAL;
            check_word("hdump", 16'(hdump), 16'(m_h));
            check_word("vdump", 16'(vdump), 16'(m_v));
            if (m_h == 0) begin
                line1 = layer_regs(0);
                line2 = layer_regs(1);
            end
            pred = predict_rgb(m_h, m_v);
            if (video_check && hist_cnt >= 1) begin
                check_addr("rom1_addr", rom1_addr, exp_addr1);
                check_addr("rom2_addr", rom2_addr, exp_addr2);
            end
            if (video_check && hist_cnt >= PIPE_DLY)
                check_rgb("rgb", rgb, exp_hist[2]);
            if (video_check && m_h < H_ACTIVE && m_v < V_ACTIVE) begin
                if (layer_pixel(1'b1, line2, m_h, m_v) != 4'd0)
                    front_wins++;
                else
                    back_shows++;
            end
            exp_addr1   = layer_addr(line1, m_h, m_v);
            exp_addr2   = layer_addr(line2, m_h, m_v);
            exp_hist[2] = exp_hist[1];
            exp_hist[1] = exp_hist[0];
            exp_hist[0] = pred;
            hist_cnt++;
        end
    endtask

    task automatic wait_pos(int h, int v);
        int   n;
        logic hit;
        n   = 0;
        hit = 1'b0;
        while (!hit && n < 2 * FRAME_CLKS) begin
            step();
            n++;
            if (pos_sync)
                hit = (m_h == h) && (m_v == v);
            else
                hit = (int'(hdump) == h) && (int'(vdump) == v);
        end
        if (!hit) begin
            $display("ERROR: timeout waiting for position %0d,%0d", h, v);
            $display("Test failures found");
            $finish;
        end
    endtask

    task automatic mmr_write(mmr_reg_e idx, logic [15:0] data, logic [1:0] dsn);
        mmr_cs         = 1'b1;
        cpu_bus.addr   = idx;
        cpu_bus.data   = data;
        cpu_bus.dsn    = dsn;
        model_mmr[idx] = lane_merge(model_mmr[idx], data, dsn);
        step();
        mmr_cs = 1'b0;
    endtask

    task automatic pal_write(logic [4:0] addr, logic [15:0] data, logic [1:0] dsn);
        logic [15:0] merged;
        merged          = lane_merge({1'b0, model_pal[addr]}, data, dsn);
        pal_cs          = 1'b1;
        cpu_pal_addr    = addr;
        cpu_bus.data    = data;
        cpu_bus.dsn     = dsn;
        model_pal[addr] = merged[14:0];
        step();
        pal_cs = 1'b0;
    endtask

    task automatic set_scroll(logic both);
        mmr_write(REG_SCR1_HPOS, 16'(rand_next()), 2'b00);
        mmr_write(REG_SCR1_VPOS, 16'(rand_next()), 2'b00);
        mmr_write(REG_PAGES, 16'(rand_next()), 2'b00);
        if (both) begin
            mmr_write(REG_SCR2_HPOS, 16'(rand_next()), 2'b00);
            mmr_write(REG_SCR2_VPOS, 16'(rand_next()), 2'b00);
        end
    endtask

    // Checks every position of one whole frame
    task automatic run_frame();
        wait_pos(H_TOTAL - 1, V_TOTAL - 1);
        video_check = 1'b1;
        hist_cnt    = 0;
        for (int i = 0; i < FRAME_CLKS + PIPE_DLY; i++)
            step();
        video_check = 1'b0;
    endtask

    task automatic report_test(string name);
        tests_run++;
        if (err_cnt > test_err_base) begin
            tests_failed++;
            $display("FAIL  %s with %0d errors", name, err_cnt - test_err_base);
        end else begin
            $display("PASS  %s", name);
        end
        test_err_base = err_cnt;
    endtask

    initial begin
        mmr_reg_e   idx;
        logic [4:0] rd;
        int         vint_cnt;
        int         cyc;
        int         wr_h;
        rst_n         = 1'b0;
        mmr_cs        = 1'b0;
        pal_cs        = 1'b0;
        cpu_bus       = '0;
        cpu_pal_addr  = '0;
        st_addr       = '0;
        pos_sync      = 1'b0;
        video_check   = 1'b0;
        hist_cnt      = 0;
        err_cnt       = 0;
        tests_run     = 0;
        tests_failed  = 0;
        test_err_base = 0;
        line1         = '0;
        line2         = '0;
        for (int i = 0; i < 5; i++)
            model_mmr[i] = '0;
        for (int i = 0; i < 16384; i++) begin
            rom1_img[i] = rand_next();
            rom2_img[i] = '0;
        end
        for (int i = 0; i < 5; i++)
            step();
        rst_n = 1'b1;

        // Lock the model counters onto the last position of a frame
        wait_pos(H_TOTAL - 1, V_TOTAL - 1);
        m_h      = H_TOTAL - 1;
        m_v      = V_TOTAL - 1;
        pos_sync = 1'b1;
        vint_cnt = 0;
        for (int i = 0; i < 2 * FRAME_CLKS; i++) begin
            step();
            check_bit("hs", hs, m_h >= HS_START && m_h < HS_END);
            check_bit("vs", vs, m_v >= VS_START && m_v < VS_END);
            check_bit("hblank", hblank, m_h >= H_ACTIVE);
            check_bit("vblank", vblank, m_v >= V_ACTIVE);
            check_bit("vint", vint, m_h == 0 && m_v == VINT_LINE);
            if (vint)
                vint_cnt++;
        end
        if (vint_cnt != 2) begin
            $display("ERROR: vint pulsed %0d times in two frames instead of 2", vint_cnt);
            err_cnt++;
        end
        report_test("timing and syncs");

        for (int i = 0; i < 40; i++) begin
            idx = mmr_reg_e'(rand_next() % 5);
            mmr_write(idx, 16'(rand_next()), 2'(rand_next()));
            for (int a = 0; a < 8; a++) begin
                st_addr = 3'(a);
                step();
                check_byte("st_dout", st_dout, (a < 5) ? model_mmr[a][7:0] : 8'h00);
            end
        end
        report_test("register access");

        // Every entry written once before the random writes
        for (int a = 0; a < 32; a++)
            pal_write(5'(a), 16'(rand_next()), 2'b00);
        for (int i = 0; i < 40; i++) begin
            pal_write(5'(rand_next()), 16'(rand_next()), 2'(rand_next()));
            rd           = 5'(rand_next());
            cpu_pal_addr = rd;
            step();
            check_word("pal_dout", pal_dout, {1'b0, model_pal[rd]});
        end
        report_test("palette access");

        set_scroll(1'b0);
        run_frame();
        report_test("back layer only");

        for (int i = 0; i < 16384; i++)
            rom2_img[i] = rand_next();
        set_scroll(1'b1);
        front_wins = 0;
        back_shows = 0;
        run_frame();
        if (front_wins == 0 || back_shows == 0) begin
            $display("ERROR: priority not exercised, %0d front and %0d back pixels",
                     front_wins, back_shows);
            err_cnt++;
        end
        report_test("layer priority");

        // Scroll writes inside every fourth line
        wait_pos(H_TOTAL - 1, V_TOTAL - 1);
        video_check = 1'b1;
        hist_cnt    = 0;
        wr_h        = 1 + int'(rand_next() % (H_TOTAL - 2));
        cyc         = 0;
        while (cyc < FRAME_CLKS + PIPE_DLY) begin
            if (m_v % 4 == 1 && m_h == wr_h) begin
                idx = ((rand_next() & 1) != 0) ? REG_SCR1_HPOS : REG_SCR2_VPOS;
                mmr_write(idx, 16'(rand_next()), 2'b00);
                wr_h = 1 + int'(rand_next() % (H_TOTAL - 2));
            end else begin
                step();
            end
            cyc++;
        end
        video_check = 1'b0;
        report_test("mid-frame scroll write");

        $display("Tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, err_cnt);
        if (tests_failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+verif
source/video_pkg.sv
source/video_timer.sv
source/video_mmr.sv
source/scroll_layer.sv
source/color_mixer.sv
source/video_top.sv
verif/tb_video_top.sv

// ==== Makefile ====
# Verilator build and run of the video subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_video_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and fail unless the run passes"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
